// File: cache/cache_data_store.sv
`timescale 1ns/100ps

module cache_data_store import cache_types_pkg::*; #(
	parameter int LINE_WORDS = 4,
	parameter int LINE_COUNT = 32,
	localparam int DEPTH = LINE_COUNT * LINE_WORDS,
	localparam int AW = $clog2(DEPTH)
) (
	input  logic          clk,
	input  byte_en_t      we,
	input  logic [AW-1:0] waddr,
	input  word_t         wdata,
	input  logic [AW-1:0] raddr,
	output word_t         rdata
);

	// Word RAM laid out as {way, set, offset}
	word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		// Each lane written on its own
		for (int b = 0; b < $bits(byte_en_t); b++) begin
			if (we[b])
				mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
		end
		// Registered read, valid the cycle after raddr
		rdata <= mem[raddr];
	end

endmodule

// File: cache/cache_refill_ctrl.sv
`timescale 1ns/100ps

module cache_refill_ctrl import qpi_bus_pkg::*; #(
	parameter int LINE_WORDS = 4,
	parameter int LINE_COUNT = 32,
	parameter int ADDR_WIDTH = 21,
	localparam int SET_BITS = $clog2(LINE_COUNT / 2),
	localparam int OFF_BITS = $clog2(LINE_WORDS),
	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFF_BITS
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                miss,
	input  logic                victim_way,
	input  logic                victim_dirty,
	input  logic [TAG_BITS-1:0] victim_tag,
	input  logic [TAG_BITS-1:0] req_tag,
	input  logic [SET_BITS-1:0] set_idx,
	input  qpi_rsp_t            rsp,
	output qpi_cmd_t            cmd,
	output logic [OFF_BITS-1:0] line_offset,
	output logic                fill_we,
	output logic [1:0]          fill_done,
	output logic                wb_done,
	output logic                busy
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_IDLE,
		ST_WRITE_BACK,
		ST_REFILL
	} state_t;

	state_t state;
	logic do_read_q;
	logic do_write_q;
	byte_addr_t burst_addr;
	logic last_word;
	logic [ADDR_WIDTH-1:0] victim_line;
	logic [ADDR_WIDTH-1:0] req_line;

	// Line start word addresses with zero offset bits
	assign victim_line = {victim_tag, set_idx, {OFF_BITS{1'b0}}};
	assign req_line = {req_tag, set_idx, {OFF_BITS{1'b0}}};

	// Offset wraps to zero after the last word
	assign last_word = rsp.next_word && (&line_offset);

	// Refill words go straight into the data store on each pulse
	assign fill_we = (state == ST_REFILL) && rsp.next_word;
	// Tag and valid of the victim way set with the last word
	assign fill_done = (fill_we && (&line_offset)) ? (2'b01 << victim_way) : 2'b00;
	assign wb_done = (state == ST_WRITE_BACK) && last_word;
	assign busy = (state != ST_IDLE);

	// Write data is added by the cache from its data store
	assign cmd.do_read = do_read_q;
	assign cmd.do_write = do_write_q;
	assign cmd.addr = burst_addr;
	assign cmd.wdata = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			do_read_q <= 1'b0;
			do_write_q <= 1'b0;
			line_offset <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (miss)
						state <= ST_WAIT_IDLE;
				end
				ST_WAIT_IDLE: begin
					// pacer may still be closing the previous burst
					if (rsp.idle) begin
						line_offset <= '0;
						if (victim_dirty) begin
							// Flush the LRU line first
							do_write_q <= 1'b1;
							burst_addr <= byte_addr_t'({victim_line, 2'b00});
							state <= ST_WRITE_BACK;
						end else begin
							do_read_q <= 1'b1;
							burst_addr <= byte_addr_t'({req_line, 2'b00});
							state <= ST_REFILL;
						end
					end
				end
				ST_WRITE_BACK: begin
					if (rsp.next_word)
						line_offset <= line_offset + 1'b1;
					// Dirty bit is clear now and the refill follows
					if (last_word) begin
						do_write_q <= 1'b0;
						state <= ST_WAIT_IDLE;
					end
				end
				ST_REFILL: begin
					if (rsp.next_word)
						line_offset <= line_offset + 1'b1;
					// Request hits on the next cycle
					if (last_word) begin
						do_read_q <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_one_direction: assert property (@(posedge clk) disable iff (rst)
		!(do_read_q && do_write_q))
		else $error("read and write burst requested together");

	// The pacer only pulses inside a burst that this FSM holds open
	a_pulse_in_burst: assert property (@(posedge clk) disable iff (rst)
		rsp.next_word |-> (do_read_q || do_write_q))
		else $error("next_word pulse outside a burst");

endmodule

// File: cache/cache_tag_store.sv
`timescale 1ns/100ps

module cache_tag_store import cache_types_pkg::*; #(
	parameter int LINE_WORDS = 4,
	parameter int LINE_COUNT = 32,
	parameter int ADDR_WIDTH = 21,
	localparam int SETS = LINE_COUNT / CACHE_WAYS,
	localparam int SET_BITS = $clog2(SETS),
	localparam int OFF_BITS = $clog2(LINE_WORDS),
	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFF_BITS
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [SET_BITS-1:0]   set_idx,
	input  logic [TAG_BITS-1:0]   req_tag,
	input  logic                  access,
	input  logic                  access_write,
	input  logic [CACHE_WAYS-1:0] fill_done,
	input  logic                  wb_done,
	output logic                  hit,
	output logic                  hit_way,
	output logic                  victim_way,
	output logic                  victim_dirty,
	output logic [TAG_BITS-1:0]   victim_tag,
	output set_flags_t            flags
);

	// Tag per way and set, only written when a line is refilled
	logic [TAG_BITS-1:0] tag_mem [CACHE_WAYS][SETS];
	set_flags_t flag_q [SETS];
	set_flags_t flags_next;
	logic [CACHE_WAYS-1:0] way_hit;

	// Flags and tags are read combinationally for the addressed set
	assign flags = flag_q[set_idx];

	always_comb begin
		for (int w = 0; w < CACHE_WAYS; w++) begin
			// An invalid way never matches, whatever its tag holds
			way_hit[w] = flags.valid[w] && (tag_mem[w][set_idx] == req_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// Victim is always the LRU way
	assign victim_way = flags.lru;
	assign victim_dirty = flags.dirty[victim_way];
	assign victim_tag = tag_mem[victim_way][set_idx];

	always_comb begin
		flags_next = flags;
		if (access) begin
			// Other way becomes the next victim
			flags_next.lru = !hit_way;
			if (access_write)
				flags_next.dirty[hit_way] = 1'b1;
		end
		// Writeback finished, line matches memory again
		if (wb_done)
			flags_next.dirty[victim_way] = 1'b0;
		for (int w = 0; w < CACHE_WAYS; w++) begin
			if (fill_done[w]) begin
				flags_next.valid[w] = 1'b1;
				flags_next.dirty[w] = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++)
				flag_q[s] <= '0;
		end else if (access || wb_done || (fill_done != '0)) begin
			flag_q[set_idx] <= flags_next;
		end
	end

	// New tag lands together with the last refill word
	always_ff @(posedge clk) begin
		for (int w = 0; w < CACHE_WAYS; w++) begin
			if (fill_done[w])
				tag_mem[w][set_idx] <= req_tag;
		end
	end

	// A refill never loads a tag that the other way already holds
	a_single_way_hit: assert property (@(posedge clk) disable iff (rst) !(&way_hit))
		else $error("both ways hit in set %0d", set_idx);

endmodule

// File: cache/qpi_cache.sv
`timescale 1ns/100ps

module qpi_cache import cache_types_pkg::*, qpi_bus_pkg::*; #(
	parameter int LINE_WORDS = 4,
	parameter int LINE_COUNT = 32,
	parameter int ADDR_WIDTH = 21,
	localparam int SET_BITS = $clog2(LINE_COUNT / 2),
	localparam int OFF_BITS = $clog2(LINE_WORDS),
	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFF_BITS,
	localparam int STORE_AW = 1 + SET_BITS + OFF_BITS
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  cpu_req_t              cpu_req,
	output word_t                 rdata,
	output logic                  ready,
	output qpi_cmd_t              qpi_cmd,
	input  qpi_rsp_t              qpi_rsp
);

	logic [TAG_BITS-1:0] req_tag;
	logic [TAG_BITS-1:0] victim_tag;
	logic [SET_BITS-1:0] set_idx;
	logic [OFF_BITS-1:0] cpu_offset;
	logic [OFF_BITS-1:0] line_offset;
	logic req_active;
	logic hit_go;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic fill_we;
	logic wb_done;
	logic busy;
	logic [CACHE_WAYS-1:0] fill_done;
	set_flags_t flags;
	qpi_cmd_t ctrl_cmd;
	logic [STORE_AW-1:0] store_addr;
	byte_en_t store_we;
	word_t store_wdata;
	word_t store_rdata;

	// addr = {tag, set, offset}
	assign {req_tag, set_idx, cpu_offset} = addr;
	assign req_active = cpu_req.ren || (cpu_req.wen != '0);
	// Hit path is locked out for the whole miss sequence
	assign hit_go = req_active && hit && !busy;

	cache_tag_store #(
		.LINE_WORDS(LINE_WORDS),
		.LINE_COUNT(LINE_COUNT),
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_tags (
		.clk(clk),
		.rst(rst),
		.set_idx(set_idx),
		.req_tag(req_tag),
		.access(hit_go),
		.access_write(cpu_req.wen != '0),
		.fill_done(fill_done),
		.wb_done(wb_done),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.flags(flags)
	);

	cache_refill_ctrl #(
		.LINE_WORDS(LINE_WORDS),
		.LINE_COUNT(LINE_COUNT),
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_refill (
		.clk(clk),
		.rst(rst),
		.miss(req_active && !hit),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.req_tag(req_tag),
		.set_idx(set_idx),
		.rsp(qpi_rsp),
		.cmd(ctrl_cmd),
		.line_offset(line_offset),
		.fill_we(fill_we),
		.fill_done(fill_done),
		.wb_done(wb_done),
		.busy(busy)
	);

	// Data store belongs to the refill path while a miss is open
	always_comb begin
		if (busy) begin
			store_addr = {victim_way, set_idx, line_offset};
			store_we = {$bits(byte_en_t){fill_we}};
			store_wdata = qpi_rsp.rdata;
		end else begin
			store_addr = {hit_way, set_idx, cpu_offset};
			store_we = hit_go ? cpu_req.wen : '0;
			store_wdata = cpu_req.wdata;
		end
	end

	cache_data_store #(
		.LINE_WORDS(LINE_WORDS),
		.LINE_COUNT(LINE_COUNT)
	) i_data (
		.clk(clk),
		.we(store_we),
		.waddr(store_addr),
		.wdata(store_wdata),
		.raddr(store_addr),
		.rdata(store_rdata)
	);

	// Writeback data is the victim word read one cycle earlier
	always_comb begin
		qpi_cmd = ctrl_cmd;
		qpi_cmd.wdata = store_rdata;
	end

	assign rdata = store_rdata;

	// ready lines up with the registered data read
	always_ff @(posedge clk) begin
		if (rst)
			ready <= 1'b0;
		else
			ready <= hit_go;
	end

	// A dirty way always holds a valid line
	a_dirty_is_valid: assert property (@(posedge clk) disable iff (rst)
		(flags.dirty & ~flags.valid) == '0)
		else $error("dirty flag on an invalid way in set %0d", set_idx);

endmodule

// File: common/cache_types_pkg.sv
package cache_types_pkg;

	// One data word as seen by the CPU and the memory
	typedef logic [31:0] word_t;

	// Byte lane write enables, zero means no write
	typedef logic [3:0] byte_en_t;

	// Ways per set, the LRU logic only knows two
	localparam int CACHE_WAYS = 2;

	// Flags of one set
	typedef struct packed {
		// Way to replace on the next miss
		logic                  lru;
		logic [CACHE_WAYS-1:0] valid;
		logic [CACHE_WAYS-1:0] dirty;
	} set_flags_t;

	// CPU request, held until ready
	typedef struct packed {
		logic     ren;
		byte_en_t wen;
		word_t    wdata;
	} cpu_req_t;

endpackage

// File: common/qpi_bus_pkg.sv
package qpi_bus_pkg;

	import cache_types_pkg::*;

	// Byte address on the serial memory side
	typedef logic [23:0] byte_addr_t;

	// Word address on the external memory port
	typedef logic [21:0] mem_addr_t;

	// Burst command from the cache, held for the whole burst
	typedef struct packed {
		logic       do_read;
		logic       do_write;
		// Line aligned
		byte_addr_t addr;
		word_t      wdata;
	} qpi_cmd_t;

	// Per word response from the pacer
	typedef struct packed {
		logic  next_word;
		word_t rdata;
		logic  idle;
	} qpi_rsp_t;

	// One strobe per word, read data comes back a cycle later
	typedef struct packed {
		logic      valid;
		logic      write;
		mem_addr_t addr;
		word_t     wdata;
	} mem_cmd_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and searches the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module cache_tb -f vlog.f \
	-o cache_sim > build.log 2>&1 \
	&& ./obj_dir/cache_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"

grep -qx "TEST PASSED" sim.log 2> /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb/cache_tb.sv
`timescale 1ns/100ps

module cache_tb import cache_types_pkg::*, qpi_bus_pkg::*; ();

	localparam int LINE_WORDS = 4;
	localparam int LINE_COUNT = 32;
	localparam int ADDR_WIDTH = 21;
	localparam int WORD_LATENCY = 3;
	localparam int OFF_BITS = $clog2(LINE_WORDS);
	localparam int SET_BITS = $clog2(LINE_COUNT / 2);
	localparam int MEM_WORDS = 4096;
	// Four tags over all sets force evictions
	localparam int RANDOM_WINDOW = 256;
	localparam int RANDOM_OPS = 300;
	localparam int DIRECTED_OPS = 25;
	// Worst case per request is a writeback and a refill burst
	localparam int REQUEST_CYCLES = 2 * LINE_WORDS * (WORD_LATENCY + 1) + 10;
	localparam int WATCHDOG_CYCLES = (RANDOM_OPS + DIRECTED_OPS) * REQUEST_CYCLES + 10;

	logic clk = 1'b0;
	logic rst;
	logic [ADDR_WIDTH-1:0] addr;
	cpu_req_t cpu_req;
	word_t rdata;
	logic ready;
	mem_cmd_t mem_cmd;
	word_t mem_rdata;

	// Flat copy of what memory plus cache should hold
	word_t shadow [MEM_WORDS];
	// Read responses waiting for the compare process
	string name_q [$];
	word_t exp_q [$];
	word_t got_q [$];
	event resp_evt;
	string cur_test;
	int test_errors = 0;
	int total_errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;

	always #20 clk = ~clk;

	cache_subsys_top #(
		.LINE_WORDS(LINE_WORDS),
		.LINE_COUNT(LINE_COUNT),
		.ADDR_WIDTH(ADDR_WIDTH),
		.WORD_LATENCY(WORD_LATENCY)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.cpu_req(cpu_req),
		.rdata(rdata),
		.ready(ready),
		.mem_cmd(mem_cmd),
		.mem_rdata(mem_rdata)
	);

	tb_backing_mem #(
		.DEPTH(MEM_WORDS),
		.LINE_WORDS(LINE_WORDS)
	) i_mem (
		.clk(clk),
		.cmd(mem_cmd),
		.rdata(mem_rdata)
	);

	// Fill pattern where every address bit reaches every data bit
	function automatic word_t addr_hash(int a);
		word_t x;
		x = word_t'(a) * 32'h9e3779b1;
		x = x ^ (x >> 15);
		x = x * 32'h85ebca6b;
		x = x ^ (x >> 13);
		return x;
	endfunction

	// Reference model of a byte-enabled write
	function automatic word_t merge_bytes(word_t old, word_t data, byte_en_t be);
		word_t res;
		res = old;
		for (int b = 0; b < $bits(byte_en_t); b++) begin
			if (be[b])
				res[8*b +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	// Word address from {tag, set, offset}
	function automatic int word_addr(int tag, int set, int off);
		return (tag << (SET_BITS + OFF_BITS)) | (set << OFF_BITS) | off;
	endfunction

	task automatic check_word(string what, word_t exp, word_t got);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s, %s: expected %08h, actual %08h", cur_test, what, exp, got);
			test_errors++;
		end
	endtask

	task automatic check_count(string what, int exp, int got);
		checks++;
		if (got != exp) begin
			$display("FAILED %s, %s: expected %0d, actual %0d", cur_test, what, exp, got);
			test_errors++;
		end
	endtask

	// Holds the request until ready and counts the cycles up to it in lat
	task automatic cpu_access(string what, int a, logic ren, byte_en_t wen, word_t wdata,
		output int lat);
		addr = ADDR_WIDTH'(a);
		cpu_req.ren = ren;
		cpu_req.wen = wen;
		cpu_req.wdata = wdata;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!ready);
		if (ren) begin
			name_q.push_back(what);
			exp_q.push_back(shadow[a]);
			got_q.push_back(rdata);
			->resp_evt;
		end
		if (wen != '0)
			shadow[a] = merge_bytes(shadow[a], wdata, wen);
		cpu_req = '0;
		// One idle cycle between requests
		@(negedge clk);
	endtask

	task automatic read_word(string what, int a, output int lat);
		cpu_access(what, a, 1'b1, '0, '0, lat);
	endtask

	task automatic write_word(int a, byte_en_t be, word_t data);
		int lat;
		cpu_access("write", a, 1'b0, be, data, lat);
	endtask

	task automatic start_test(string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("%s: %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "failed",
			test_errors);
	endtask

	// Compares each read response with the reference word
	initial begin
		forever begin
			@(resp_evt);
			while (got_q.size() > 0)
				check_word(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
		end
	end

	initial begin
		int lat;
		int a;
		int rd0;
		int wr0;
		int wb0;
		int d_line;
		byte_en_t be;
		word_t data;

		void'($urandom(32'h277aff68));
		rst = 1'b1;
		addr = '0;
		cpu_req = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = addr_hash(i);
			i_mem.mem[i] = shadow[i];
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// Cold miss refills the line and a second word of it hits
		start_test("cold_read_miss");
		rd0 = i_mem.read_words;
		read_word("cold miss data", word_addr(1, 3, 2), lat);
		check_count("cold miss refill words", LINE_WORDS, i_mem.read_words - rd0);
		read_word("repeat read data", word_addr(1, 3, 0), lat);
		check_count("repeat read latency", 1, lat);
		end_test();

		// Partial writes merge with the refilled words
		start_test("byte_writes");
		a = word_addr(2, 5, 0);
		write_word(a, 4'b0011, 32'h1122_3344);
		write_word(a + 1, 4'b1100, 32'h5566_7788);
		write_word(a + 2, 4'b0101, 32'hdead_beef);
		write_word(a + 3, 4'b1111, 32'h0bad_f00d);
		write_word(a, 4'b1000, 32'ha500_0000);
		for (int i = 0; i < LINE_WORDS; i++)
			read_word("merged word", a + i, lat);
		end_test();

		// A, B, A, then C must push B out
		start_test("lru_replacement");
		read_word("line A", word_addr(2, 7, 0), lat);
		read_word("line B", word_addr(3, 7, 0), lat);
		read_word("line A again", word_addr(2, 7, 1), lat);
		check_count("line A reuse latency", 1, lat);
		read_word("line C", word_addr(4, 7, 0), lat);
		rd0 = i_mem.read_words;
		read_word("line A after C", word_addr(2, 7, 2), lat);
		check_count("line A kept latency", 1, lat);
		check_count("line A kept refill words", 0, i_mem.read_words - rd0);
		rd0 = i_mem.read_words;
		read_word("line B after C", word_addr(3, 7, 3), lat);
		check_count("line B evicted refill words", LINE_WORDS, i_mem.read_words - rd0);
		end_test();

		// Dirty line D goes back to memory when F replaces it
		start_test("dirty_eviction");
		d_line = word_addr(5, 9, 0);
		write_word(d_line + 1, 4'b1111, 32'hcafe_0001);
		write_word(d_line + 2, 4'b0110, 32'h00ab_cd00);
		read_word("line E", word_addr(6, 9, 0), lat);
		wr0 = i_mem.write_words;
		wb0 = i_mem.wb_lines;
		read_word("line F", word_addr(7, 9, 0), lat);
		check_count("writeback words", LINE_WORDS, i_mem.write_words - wr0);
		check_count("writeback bursts", 1, i_mem.wb_lines - wb0);
		check_count("writeback line address", d_line, int'(i_mem.last_wb_line));
		for (int i = 0; i < LINE_WORDS; i++)
			check_word("written back word", shadow[d_line + i], i_mem.mem[d_line + i]);
		read_word("line D reread", d_line + 1, lat);
		read_word("line D reread", d_line + 2, lat);
		end_test();

		// Mixed traffic over a few tags per set
		start_test("random_traffic");
		for (int n = 0; n < RANDOM_OPS; n++) begin
			a = int'($urandom_range(RANDOM_WINDOW - 1, 0));
			if ($urandom_range(1, 0) == 0) begin
				read_word("random read", a, lat);
			end else begin
				be = byte_en_t'($urandom_range(15, 1));
				data = $urandom();
				write_word(a, be, data);
			end
		end
		check_count("strobes outside memory window", 0, i_mem.range_errors);
		end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, total_errors);
		if (total_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Stops a run where the DUT never answers
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, a request never got ready",
			WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tb/tb_backing_mem.sv
`timescale 1ns/100ps

module tb_backing_mem import cache_types_pkg::*, qpi_bus_pkg::*; #(
	parameter int DEPTH = 4096,
	parameter int LINE_WORDS = 4,
	localparam int AW = $clog2(DEPTH),
	localparam int OFF_BITS = $clog2(LINE_WORDS)
) (
	input  logic     clk,
	input  mem_cmd_t cmd,
	output word_t    rdata
);

	// External word memory that the testbench fills before reset
	word_t mem [DEPTH];
	// Read data register starts at zero
	word_t rdata_q = '0;

	// Strobe statistics that the testbench samples between requests
	int read_words = 0;
	int write_words = 0;
	// One write burst per line written back
	int wb_lines = 0;
	int range_errors = 0;
	mem_addr_t last_wb_line = '0;

	assign rdata = rdata_q;

	always @(posedge clk) begin
		if (cmd.valid) begin
			if (cmd.addr >= mem_addr_t'(DEPTH)) begin
				// Outside the modelled window
				range_errors <= range_errors + 1;
			end else if (cmd.write) begin
				// Only one strobe per cycle and no write can race a read
				mem[cmd.addr[AW-1:0]] = cmd.wdata;
				write_words <= write_words + 1;
				// Writeback bursts are line aligned
				if (cmd.addr[OFF_BITS-1:0] == '0) begin
					wb_lines <= wb_lines + 1;
					last_wb_line <= cmd.addr;
				end
			end else begin
				// Read data shows up one cycle after the strobe
				rdata_q <= mem[cmd.addr[AW-1:0]];
				read_words <= read_words + 1;
			end
		end
	end

endmodule

// File: verilog/cache_subsys_top.sv
`timescale 1ns/100ps

module cache_subsys_top import cache_types_pkg::*, qpi_bus_pkg::*; #(
	parameter int LINE_WORDS = 4,
	parameter int LINE_COUNT = 32,
	// Word address
	parameter int ADDR_WIDTH = 21,
	parameter int WORD_LATENCY = 3
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  cpu_req_t              cpu_req,
	output word_t                 rdata,
	output logic                  ready,
	output mem_cmd_t              mem_cmd,
	input  word_t                 mem_rdata
);

	// Burst command port between cache and pacer
	qpi_cmd_t qpi_cmd;
	qpi_rsp_t qpi_rsp;

	qpi_cache #(
		.LINE_WORDS(LINE_WORDS),
		.LINE_COUNT(LINE_COUNT),
		.ADDR_WIDTH(ADDR_WIDTH)
	) i_cache (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.cpu_req(cpu_req),
		.rdata(rdata),
		.ready(ready),
		.qpi_cmd(qpi_cmd),
		.qpi_rsp(qpi_rsp)
	);

	// Stands in for the serial memory controller
	qpi_word_pacer #(
		.WORD_LATENCY(WORD_LATENCY)
	) i_pacer (
		.clk(clk),
		.rst(rst),
		.cmd(qpi_cmd),
		.mem_rdata(mem_rdata),
		.rsp(qpi_rsp),
		.mem_cmd(mem_cmd)
	);

endmodule

// File: verilog/qpi_word_pacer.sv
`timescale 1ns/100ps

module qpi_word_pacer import cache_types_pkg::*, qpi_bus_pkg::*; #(
	// At least 2, the cache needs a cycle to present the next writeback word
	parameter int WORD_LATENCY = 3,
	localparam int CNT_BITS = $clog2(WORD_LATENCY + 1)
) (
	input  logic     clk,
	input  logic     rst,
	input  qpi_cmd_t cmd,
	input  word_t    mem_rdata,
	output qpi_rsp_t rsp,
	output mem_cmd_t mem_cmd
);

	// Strobe one cycle before the pulse so read data is back in time
	localparam logic [CNT_BITS-1:0] STROBE_CNT = CNT_BITS'(WORD_LATENCY - 1);
	localparam logic [CNT_BITS-1:0] PULSE_CNT = CNT_BITS'(WORD_LATENCY);

	logic busy;
	logic go;
	logic [CNT_BITS-1:0] cnt;
	mem_addr_t word_addr;

	assign go = cmd.do_read || cmd.do_write;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (!busy) begin
			if (go) begin
				busy <= 1'b1;
				cnt <= '0;
			end
		end else if (!go) begin
			// Cache dropped the command after its last word
			busy <= 1'b0;
		end else if (cnt == PULSE_CNT) begin
			// Go straight on to the next word of the burst
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Word address loaded at burst start, stepped per pulse
	always_ff @(posedge clk) begin
		if (!busy && go)
			word_addr <= cmd.addr[$bits(byte_addr_t)-1:2];
		else if (rsp.next_word)
			word_addr <= word_addr + 1'b1;
	end

	// Memory samples wdata with the strobe
	assign mem_cmd.valid = busy && go && (cnt == STROBE_CNT);
	assign mem_cmd.write = cmd.do_write;
	assign mem_cmd.addr = word_addr;
	assign mem_cmd.wdata = cmd.wdata;

	// read data from the previous strobe is on mem_rdata now
	assign rsp.next_word = busy && (cnt == PULSE_CNT);
	assign rsp.rdata = mem_rdata;
	assign rsp.idle = !busy;

endmodule

// File: vlog.f
common/cache_types_pkg.sv
common/qpi_bus_pkg.sv
cache/cache_tag_store.sv
cache/cache_data_store.sv
cache/cache_refill_ctrl.sv
cache/qpi_cache.sv
verilog/qpi_word_pacer.sv
verilog/cache_subsys_top.sv
tb/tb_backing_mem.sv
tb/cache_tb.sv
